/* design/cp0Pkg.sv */
package cp0Pkg;

    // Widths with a meaning of their own
    typedef logic [31:0] word_t;      // Data or address word
    typedef logic [4:0]  regNum_t;    // CP0 register number (Rd field)
    typedef logic [3:0]  excCode_t;   // Cause.ExcCode, bit 4 is never used here
    typedef logic [7:0]  intVec_t;    // One bit per interrupt line
    typedef logic [4:0]  extInt_t;    // External hardware interrupt pins

    // Implemented CP0 registers, select 0 only
    localparam regNum_t regBadVAddr = 5'd8;
    localparam regNum_t regCount    = 5'd9;
    localparam regNum_t regCompare  = 5'd11;
    localparam regNum_t regStatus   = 5'd12;
    localparam regNum_t regCause    = 5'd13;
    localparam regNum_t regEpc      = 5'd14;

    // Cause.ExcCode values
    localparam excCode_t excInt  = 4'd0;
    localparam excCode_t excAdEL = 4'd4;    // Also used for instruction fetch errors
    localparam excCode_t excAdES = 4'd5;
    localparam excCode_t excSys  = 4'd8;
    localparam excCode_t excBp   = 4'd9;
    localparam excCode_t excRI   = 4'd10;
    localparam excCode_t excCpU  = 4'd11;
    localparam excCode_t excOv   = 4'd12;
    localparam excCode_t excTr   = 4'd13;

    // Status field positions
    localparam int statusBevBit = 22;     // Boot exception vectors
    localparam int statusImLsb  = 8;      // IM is 8 bits wide
    localparam int statusUmBit  = 4;      // User mode
    localparam int statusExlBit = 1;      // Exception level
    localparam int statusIeBit  = 0;      // Global interrupt enable

    // Cause field positions
    localparam int causeBdBit   = 31;     // Exception in branch delay slot
    localparam int causeIvBit   = 23;     // Special interrupt vector
    localparam int causeIpLsb   = 8;      // IP is 8 bits wide
    localparam int causeCodeLsb = 2;

    // Offsets from the vector base
    localparam word_t offsetGeneral = 32'h0000_0180;
    localparam word_t offsetSpecial = 32'h0000_0200;   // Interrupts with Cause.IV set

endpackage

/* design/cp0Timer.sv */
`timescale 1ns/1ps

module cp0Timer (
    input  logic          clock,
    input  logic          reset,
    input  logic          countWrite,     // Mtc0 to Count
    input  logic          compareWrite,   // Mtc0 to Compare
    input  logic          countRead,      // Kernel Mfc0 of Count
    input  cp0Pkg::word_t writeData,
    output cp0Pkg::word_t count,
    output cp0Pkg::word_t compare,
    output logic          timerPending    // Becomes IP[7]
);

    logic match;

    assign match = (count == compare);

    always_ff @(posedge clock) begin
        if (reset) begin
            count        <= '0;
            compare      <= '0;
            timerPending <= 1'b0;
        end else begin
            // Software write wins, else wrap to zero on a match
            if (countWrite)
                count <= writeData;
            else if (match)
                count <= '0;
            else
                count <= count + 32'd1;

            if (compareWrite)
                compare <= writeData;

            // Sticky until software reads Count
            if (countRead)
                timerPending <= 1'b0;
            else if (!timerPending)
                timerPending <= match;
        end
    end

    // Only one Mtc0 can be in ID at a time
    assert property (@(posedge clock) disable iff (reset) !(countWrite && compareWrite))
        else $error("cp0Timer: Count and Compare written in the same cycle");

endmodule

/* design/cp0Registers.sv */
`timescale 1ns/1ps

module cp0Registers (
    input  logic              clock,
    input  logic              reset,
    input  logic              mfc0,
    input  logic              mtc0,
    input  logic              idStall,
    input  cp0Pkg::regNum_t   rd,
    input  cp0Pkg::word_t     regIn,
    input  cp0Pkg::extInt_t   extInt,
    input  logic              excCommit,      // From the arbiter
    input  logic              eretCommit,
    input  logic              badAddrLoad,
    input  logic              excIsBd,
    input  cp0Pkg::excCode_t  excCode,
    input  cp0Pkg::word_t     excRestartPc,
    input  cp0Pkg::word_t     excBadAddr,
    input  cp0Pkg::word_t     count,          // From the timer
    input  cp0Pkg::word_t     compare,
    input  logic              timerPending,
    output cp0Pkg::word_t     regOut,
    output cp0Pkg::word_t     epc,
    output logic              kernelMode,
    output logic              cpUnusable,
    output logic              intRequest,
    output logic              statusBev,
    output logic              causeIv,
    output logic              statusExl,
    output cp0Pkg::intVec_t   pendingInt,
    output logic              countWrite,
    output logic              compareWrite,
    output logic              countRead,
    output cp0Pkg::word_t     writeData
);

    cp0Pkg::intVec_t  statusIm;
    logic             statusUm;
    logic             statusIe;
    logic             causeBd;
    logic [1:0]       softInt;        // IP[1:0], software owned
    cp0Pkg::extInt_t  hwInt;          // IP[6:2], registered pins
    cp0Pkg::excCode_t causeCode;
    cp0Pkg::word_t    badVAddr;
    cp0Pkg::word_t    statusWord;
    cp0Pkg::word_t    causeWord;
    logic             writeEnable;
    logic             wrStatus;
    logic             wrCause;
    logic             wrEpc;

    // EXL forces kernel mode so handlers run privileged
    assign kernelMode = ~statusUm | statusExl;
    assign cpUnusable = (mfc0 | mtc0) & ~kernelMode;
    assign pendingInt = {timerPending, hwInt, softInt};
    assign intRequest = (|(pendingInt & statusIm)) & statusIe & ~statusExl;

    assign writeEnable  = kernelMode & mtc0 & ~idStall;
    assign wrStatus     = writeEnable & (rd == cp0Pkg::regStatus);
    assign wrCause      = writeEnable & (rd == cp0Pkg::regCause);
    assign wrEpc        = writeEnable & (rd == cp0Pkg::regEpc);
    assign countWrite   = writeEnable & (rd == cp0Pkg::regCount);
    assign compareWrite = writeEnable & (rd == cp0Pkg::regCompare);
    assign countRead    = kernelMode & mfc0 & (rd == cp0Pkg::regCount);   // Clears IP[7]
    assign writeData    = regIn;

    // Architectural views, unimplemented bits read as zero
    always_comb begin
        statusWord = '0;
        statusWord[cp0Pkg::statusBevBit]     = statusBev;
        statusWord[cp0Pkg::statusImLsb +: 8] = statusIm;
        statusWord[cp0Pkg::statusUmBit]      = statusUm;
        statusWord[cp0Pkg::statusExlBit]     = statusExl;
        statusWord[cp0Pkg::statusIeBit]      = statusIe;
        causeWord = '0;
        causeWord[cp0Pkg::causeBdBit]        = causeBd;
        causeWord[cp0Pkg::causeIvBit]        = causeIv;
        causeWord[cp0Pkg::causeIpLsb +: 8]   = pendingInt;
        causeWord[cp0Pkg::causeCodeLsb +: 4] = causeCode;
    end

    // Mfc0 read mux
    always_comb begin
        regOut = '0;
        if (mfc0 && kernelMode) begin
            case (rd)
                cp0Pkg::regBadVAddr: regOut = badVAddr;
                cp0Pkg::regCount:    regOut = count;
                cp0Pkg::regCompare:  regOut = compare;
                cp0Pkg::regStatus:   regOut = statusWord;
                cp0Pkg::regCause:    regOut = causeWord;
                cp0Pkg::regEpc:      regOut = epc;
                default:             regOut = '0;
            endcase
        end
    end

    // Software owned fields, boot vectors and kernel mode out of reset
    always_ff @(posedge clock) begin
        if (reset) begin
            statusBev <= 1'b1;
            statusIm  <= '0;
            statusUm  <= 1'b0;
            statusIe  <= 1'b0;
            causeIv   <= 1'b0;
            softInt   <= '0;
            hwInt     <= '0;
        end else begin
            hwInt <= extInt;            // One cycle behind the pins
            if (wrStatus) begin
                statusBev <= regIn[cp0Pkg::statusBevBit];
                statusIm  <= regIn[cp0Pkg::statusImLsb +: 8];
                statusUm  <= regIn[cp0Pkg::statusUmBit];
                statusIe  <= regIn[cp0Pkg::statusIeBit];
            end
            if (wrCause) begin
                causeIv <= regIn[cp0Pkg::causeIvBit];
                softInt <= regIn[cp0Pkg::causeIpLsb +: 2];
            end
        end
    end

    // Exception level, code and delay-slot flag
    always_ff @(posedge clock) begin
        if (reset) begin
            statusExl <= 1'b0;
            causeBd   <= 1'b0;
            causeCode <= cp0Pkg::excInt;
        end else if (excCommit) begin
            statusExl <= 1'b1;
            causeCode <= excCode;
            if (!statusExl)
                causeBd <= excIsBd;     // Nested exception keeps the first BD
        end else begin
            causeBd <= 1'b0;
            if (wrStatus)
                statusExl <= regIn[cp0Pkg::statusExlBit];
            else if (eretCommit)
                statusExl <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (excCommit) begin
            if (!statusExl)
                epc <= excRestartPc;
            if (badAddrLoad)
                badVAddr <= excBadAddr;
        end else if (wrEpc) begin
            epc <= regIn;
        end
    end

    // The arbiter flushes an ERET whenever any exception is taken
    assert property (@(posedge clock) disable iff (reset) !(excCommit && eretCommit))
        else $error("cp0Registers: exception and ERET committed together");

endmodule

/* design/exceptionArbiter.sv */
`timescale 1ns/1ps

module exceptionArbiter #(
    parameter cp0Pkg::word_t resetVector = 32'hBFC0_0000,
    parameter cp0Pkg::word_t bootBase    = 32'hBFC0_0200,
    parameter cp0Pkg::word_t normalBase  = 32'h8000_0000
) (
    input  logic              reset,
    input  logic              eret,
    input  logic              mtc0,
    input  logic              ifStall,
    input  logic              idStall,
    input  logic              idIsFlushed,
    input  logic              excAdIf,
    input  logic              excAdEL,
    input  logic              excAdES,
    input  logic              excOv,
    input  logic              excTr,
    input  logic              excSys,
    input  logic              excBp,
    input  logic              excRI,
    input  logic              idCanErr,       // Cumulative from ID forward
    input  logic              exCanErr,       // Cumulative from EX forward
    input  logic              memCanErr,
    input  logic              ifIsBd,
    input  logic              idIsBd,
    input  logic              exIsBd,
    input  logic              memIsBd,
    input  cp0Pkg::word_t     idRestartPc,
    input  cp0Pkg::word_t     exRestartPc,
    input  cp0Pkg::word_t     memRestartPc,
    input  cp0Pkg::word_t     badAddrMem,
    input  cp0Pkg::word_t     badAddrIf,
    input  logic              cpUnusable,
    input  logic              intRequest,
    input  logic              statusBev,
    input  logic              causeIv,
    input  logic              statusExl,
    input  cp0Pkg::word_t     epc,
    output logic              ifExceptionStall,
    output logic              idExceptionStall,
    output logic              exExceptionStall,
    output logic              memExceptionStall,
    output logic              ifExceptionFlush,
    output logic              idExceptionFlush,
    output logic              exExceptionFlush,
    output logic              memExceptionFlush,
    output logic              excPcSel,
    output logic              excCommit,
    output logic              eretCommit,
    output logic              badAddrLoad,
    output logic              excIsBd,
    output cp0Pkg::word_t     excPcOut,
    output cp0Pkg::word_t     excRestartPc,
    output cp0Pkg::word_t     excBadAddr,
    output cp0Pkg::excCode_t  excCode
);

    logic          intTaken;
    logic          memDetect, exDetect, idDetect, ifDetect;
    logic          memMask, exMask, idMask, ifMask;
    logic          memReady, exReady, idReady, ifReady;
    cp0Pkg::word_t vectorBase;

    // Interrupts go in at ID, never over a flushed slot
    assign intTaken  = intRequest & ~statusExl & ~idIsFlushed;

    assign memDetect = excAdEL | excAdES | excTr;
    assign exDetect  = excOv;
    assign idDetect  = excSys | excBp | excRI | cpUnusable | intTaken;
    assign ifDetect  = excAdIf;

    // Wait while a later stage may still fault; ERET holds back IF as it redirects fetch
    assign memMask   = ifStall;
    assign exMask    = ifStall | memCanErr;
    assign idMask    = ifStall | memCanErr | exCanErr;
    assign ifMask    = memCanErr | exCanErr | idCanErr | intTaken | eret;

    assign memExceptionStall = memDetect & memMask;
    assign exExceptionStall  = exDetect & exMask & ~memDetect;
    assign idExceptionStall  = (idDetect | eret | mtc0) & idMask & ~(exDetect | memDetect);
    assign ifExceptionStall  = ifDetect & ifMask & ~(idDetect | exDetect | memDetect);

    assign memReady  = ~idStall & memDetect & ~memMask;
    assign exReady   = ~idStall & exDetect & ~exMask;
    assign idReady   = ~idStall & idDetect & ~idMask;
    assign ifReady   = ~idStall & ifDetect & ~ifMask;
    assign excCommit = memReady | exReady | idReady | ifReady;

    // ERET only retires once nothing in front of it can fault
    assign eretCommit = eret & ~idStall & ~idExceptionStall & ~(idDetect | exDetect | memDetect);

    // A faulting stage squashes itself and everything younger
    assign memExceptionFlush = memDetect;
    assign exExceptionFlush  = memDetect | exDetect;
    assign idExceptionFlush  = memDetect | exDetect | idDetect;
    assign ifExceptionFlush  = memDetect | exDetect | idDetect | ifDetect | eretCommit;

    // Commit data of the oldest ready stage
    always_comb begin
        if (memReady) begin
            excRestartPc = memRestartPc;
            excIsBd      = memIsBd;
        end else if (exReady) begin
            excRestartPc = exRestartPc;
            excIsBd      = exIsBd;
        end else if (idReady) begin
            excRestartPc = idRestartPc;
            excIsBd      = idIsBd;
        end else begin
            excRestartPc = badAddrIf;   // Fetch faults restart at the bad PC
            excIsBd      = ifIsBd;
        end
    end

    assign badAddrLoad = memReady | ifReady;
    assign excBadAddr  = memReady ? badAddrMem : badAddrIf;

    // Program order first, interrupts last
    always_comb begin
        if      (excAdEL)    excCode = cp0Pkg::excAdEL;
        else if (excAdES)    excCode = cp0Pkg::excAdES;
        else if (excTr)      excCode = cp0Pkg::excTr;
        else if (excOv)      excCode = cp0Pkg::excOv;
        else if (excSys)     excCode = cp0Pkg::excSys;
        else if (excBp)      excCode = cp0Pkg::excBp;
        else if (excRI)      excCode = cp0Pkg::excRI;
        else if (cpUnusable) excCode = cp0Pkg::excCpU;
        else if (excAdIf)    excCode = cp0Pkg::excAdEL;
        else                 excCode = cp0Pkg::excInt;
    end

    assign vectorBase = statusBev ? bootBase : normalBase;
    assign excPcSel   = reset | eretCommit | excCommit;

    always_comb begin
        if (reset)
            excPcOut = resetVector;
        else if (eretCommit)
            excPcOut = epc;
        else if (excCode == cp0Pkg::excInt && intTaken && causeIv)
            excPcOut = vectorBase + cp0Pkg::offsetSpecial;
        else
            excPcOut = vectorBase + cp0Pkg::offsetGeneral;
    end

    // The pipeline's can-error chain keeps the stages exclusive
    always_comb begin
        if (!reset)
            assert ($onehot0({memReady, exReady, idReady, ifReady}))
                else $error("exceptionArbiter: more than one stage ready");
    end

endmodule

/* design/cp0Top.sv */
`timescale 1ns/1ps

module cp0Top #(
    parameter cp0Pkg::word_t resetVector = 32'hBFC0_0000,
    parameter cp0Pkg::word_t bootBase    = 32'hBFC0_0200,
    parameter cp0Pkg::word_t normalBase  = 32'h8000_0000
) (
    input  logic              clock,
    input  logic              reset,
    input  logic              mfc0,
    input  logic              mtc0,
    input  logic              eret,
    input  logic              ifStall,
    input  logic              idStall,
    input  cp0Pkg::regNum_t   rd,
    input  cp0Pkg::word_t     regIn,
    input  cp0Pkg::extInt_t   extInt,
    input  logic              idIsFlushed,
    input  logic              excAdIf,
    input  logic              excAdEL,
    input  logic              excAdES,
    input  logic              excOv,
    input  logic              excTr,
    input  logic              excSys,
    input  logic              excBp,
    input  logic              excRI,
    input  cp0Pkg::word_t     idRestartPc,
    input  cp0Pkg::word_t     exRestartPc,
    input  cp0Pkg::word_t     memRestartPc,
    input  logic              ifIsBd,
    input  logic              idIsBd,
    input  logic              exIsBd,
    input  logic              memIsBd,
    input  cp0Pkg::word_t     badAddrMem,
    input  cp0Pkg::word_t     badAddrIf,
    input  logic              idCanErr,
    input  logic              exCanErr,
    input  logic              memCanErr,
    output cp0Pkg::word_t     regOut,
    output logic              kernelMode,
    output logic              ifExceptionStall,
    output logic              idExceptionStall,
    output logic              exExceptionStall,
    output logic              memExceptionStall,
    output logic              ifExceptionFlush,
    output logic              idExceptionFlush,
    output logic              exExceptionFlush,
    output logic              memExceptionFlush,
    output logic              excPcSel,
    output cp0Pkg::word_t     excPcOut,
    output cp0Pkg::intVec_t   pendingInt
);

    // Registers to arbiter
    cp0Pkg::word_t    epc;
    logic             cpUnusable, intRequest, statusBev, causeIv, statusExl;
    // Arbiter back to registers
    logic             excCommit, eretCommit, badAddrLoad, excIsBd;
    cp0Pkg::excCode_t excCode;
    cp0Pkg::word_t    excRestartPc, excBadAddr;
    // Timer link
    logic             countWrite, compareWrite, countRead, timerPending;
    cp0Pkg::word_t    writeData, count, compare;

    cp0Registers registers (.*);

    cp0Timer timer (.*);

    exceptionArbiter #(
        .resetVector(resetVector),
        .bootBase   (bootBase),
        .normalBase (normalBase)
    ) arbiter (.*);

endmodule

/* dv/cp0Tb.sv */
`timescale 1ns/1ps

module cp0Tb;

    localparam cp0Pkg::word_t resetVector = 32'hBFC0_0000;
    localparam cp0Pkg::word_t bootBase    = 32'hBFC0_0200;
    localparam cp0Pkg::word_t normalBase  = 32'h8000_0000;
    localparam cp0Pkg::word_t bootStatus  = 32'h0040_0000;   // Kernel, EXL clear, BEV set
    localparam cp0Pkg::word_t userStatus  = 32'h0040_0010;
    localparam int            timerLimit  = 20;

    logic             clock, reset, mfc0, mtc0, eret, ifStall, idStall, idIsFlushed;
    logic             excAdIf, excAdEL, excAdES, excOv, excTr, excSys, excBp, excRI;
    logic             ifIsBd, idIsBd, exIsBd, memIsBd, idCanErr, exCanErr, memCanErr;
    cp0Pkg::regNum_t  rd;
    cp0Pkg::word_t    regIn, idRestartPc, exRestartPc, memRestartPc, badAddrMem, badAddrIf;
    cp0Pkg::extInt_t  extInt;
    cp0Pkg::word_t    regOut, excPcOut;
    cp0Pkg::intVec_t  pendingInt;
    logic             kernelMode, excPcSel;
    logic             ifExceptionStall, idExceptionStall, exExceptionStall, memExceptionStall;
    logic             ifExceptionFlush, idExceptionFlush, exExceptionFlush, memExceptionFlush;
    cp0Pkg::word_t    seed;
    int               errorCount;
    int               checkCount;

    cp0Top #(
        .resetVector(resetVector),
        .bootBase   (bootBase),
        .normalBase (normalBase)
    ) UUT (.*);

    initial clock = 1'b0;
    always #20 clock = ~clock;

    function cp0Pkg::word_t nextRandom();
        seed = seed * 32'd1664525 + 32'd1013904223;   // Numerical Recipes LCG
        return seed;
    endfunction

    // Vector PC from reset, ERET, the special interrupt offset and BEV
    function automatic cp0Pkg::word_t expectedVector(input logic inReset, input logic isEret,
            input cp0Pkg::word_t epcValue, input logic specialInt, input logic bev);
        cp0Pkg::word_t base;
        base = bev ? bootBase : normalBase;
        if (inReset)
            return resetVector;
        if (isEret)
            return epcValue;
        if (specialInt)
            return base + 32'h0000_0200;
        return base + 32'h0000_0180;
    endfunction

    // Fixed priority with the interrupt last
    function automatic cp0Pkg::excCode_t expectedCode(input logic adEL, input logic adES,
            input logic tr, input logic ov, input logic sys, input logic bp, input logic ri,
            input logic cpu, input logic adIf);
        if (adEL)      return 4'd4;
        else if (adES) return 4'd5;
        else if (tr)   return 4'd13;
        else if (ov)   return 4'd12;
        else if (sys)  return 4'd8;
        else if (bp)   return 4'd9;
        else if (ri)   return 4'd10;
        else if (cpu)  return 4'd11;
        else if (adIf) return 4'd4;      // Fetch errors report AdEL
        return 4'd0;
    endfunction

    function automatic cp0Pkg::word_t statusAfterWrite(input cp0Pkg::word_t data);
        return data & 32'h0040_FF13;     // BEV, IM, UM, EXL, IE
    endfunction

    task automatic checkWord(input string name, input cp0Pkg::word_t expected,
            input cp0Pkg::word_t actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("mismatch %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic checkCode(input string name, input cp0Pkg::excCode_t expected,
            input cp0Pkg::excCode_t actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("mismatch %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic checkBit(input string name, input logic expected, input logic actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("mismatch %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    task automatic clearExceptions();
        {excAdIf, excAdEL, excAdES, excOv, excTr, excSys, excBp, excRI} = '0;
        {ifIsBd, idIsBd, exIsBd, memIsBd, idCanErr, exCanErr, memCanErr} = '0;
        eret = 1'b0;
    endtask

    // Starts on a falling edge and returns on the next one
    task automatic writeReg(input cp0Pkg::regNum_t num, input cp0Pkg::word_t data);
        mtc0  = 1'b1;
        rd    = num;
        regIn = data;
        @(negedge clock);
        mtc0 = 1'b0;
    endtask

    task automatic readReg(input cp0Pkg::regNum_t num, output cp0Pkg::word_t data);
        mfc0 = 1'b1;
        rd   = num;
        #1;
        data = regOut;                   // Combinational read
        @(negedge clock);
        mfc0 = 1'b0;
    endtask

    initial begin
        cp0Pkg::word_t    value, readValue, oldValue, flags, expEpc, expBad;
        cp0Pkg::excCode_t expCode;
        logic             memDet, exDet, idDet, ifDet, badLoaded, seen, bev;
        int               cycle;
        errorCount = 0;
        checkCount = 0;
        seed       = 32'ha9bd_c537;
        reset      = 1'b1;
        {mfc0, mtc0, ifStall, idStall, idIsFlushed} = '0;
        clearExceptions();
        rd     = '0;
        regIn  = '0;
        extInt = '0;
        {idRestartPc, exRestartPc, memRestartPc, badAddrMem, badAddrIf} = '0;

        @(negedge clock);
        #1;
        checkBit("reset pc select", 1'b1, excPcSel);
        checkWord("reset vector", expectedVector(1'b1, 1'b0, '0, 1'b0, 1'b1), excPcOut);
        repeat (4) @(negedge clock);     // Five rising edges in reset
        reset = 1'b0;
        #1;
        checkBit("kernel after reset", 1'b1, kernelMode);
        @(negedge clock);

        // Register access with UM and IE kept low
        for (int i = 0; i < 4; i++) begin
            value = nextRandom();
            writeReg(cp0Pkg::regEpc, value);
            readReg(cp0Pkg::regEpc, readValue);
            checkWord("epc write", value, readValue);
            value = nextRandom();
            writeReg(cp0Pkg::regCompare, value);
            readReg(cp0Pkg::regCompare, readValue);
            checkWord("compare write", value, readValue);
            value = nextRandom() & ~32'h0000_0011;
            writeReg(cp0Pkg::regStatus, value);
            readReg(cp0Pkg::regStatus, readValue);
            checkWord("status write", statusAfterWrite(value), readValue);
        end

        // Timer test where cycle 0 is the Count write
        writeReg(cp0Pkg::regStatus, bootStatus);
        writeReg(cp0Pkg::regCount, 32'd0);
        writeReg(cp0Pkg::regCompare, timerLimit);
        readReg(cp0Pkg::regCount, readValue);
        readReg(cp0Pkg::regCount, value);
        checkWord("count start", 32'd1, readValue);
        checkWord("count step", 32'd2, value);
        cycle = 4;
        seen  = 1'b0;
        while (!seen && cycle < timerLimit + 40) begin
            #1;
            if (pendingInt[7])
                seen = 1'b1;
            else begin
                @(negedge clock);
                cycle++;
            end
        end
        if (!seen) begin
            errorCount++;
            $display("ERROR: timer interrupt never became pending");
        end
        checkWord("timer pending cycle", timerLimit + 2, cycle);
        @(negedge clock);
        readReg(cp0Pkg::regCount, readValue);
        checkWord("count wrap", 32'd1, readValue);      // Back to zero one cycle earlier
        #1;
        checkBit("timer pending cleared", 1'b0, pendingInt[7]);
        @(negedge clock);

        // Priority across stages without stalls
        for (int i = 0; i < 8; i++) begin
            writeReg(cp0Pkg::regStatus, bootStatus);
            flags   = nextRandom();
            excAdEL = flags[0] & flags[10];
            excAdES = flags[1] & flags[10];
            excTr   = flags[2] & flags[10];
            excOv   = flags[3] & flags[11];
            excSys  = flags[4];
            excBp   = flags[5];
            excRI   = flags[6];
            excAdIf = flags[7];
            if (!(excAdEL | excAdES | excTr | excOv | excSys | excBp | excRI | excAdIf))
                excSys = 1'b1;           // At least one stage faults
            memDet = excAdEL | excAdES | excTr;
            exDet  = excOv;
            idDet  = excSys | excBp | excRI;
            ifDet  = excAdIf;
            memCanErr = memDet;          // Can-error chain as a pipeline drives it
            exCanErr  = memDet | exDet;
            idCanErr  = memDet | exDet | idDet;
            memRestartPc = nextRandom();
            exRestartPc  = nextRandom();
            idRestartPc  = nextRandom();
            badAddrMem   = nextRandom();
            badAddrIf    = nextRandom();
            expCode = expectedCode(excAdEL, excAdES, excTr, excOv, excSys, excBp, excRI,
                1'b0, excAdIf);
            expEpc = memDet ? memRestartPc : exDet ? exRestartPc : idDet ? idRestartPc :
                badAddrIf;
            badLoaded = memDet | ~(exDet | idDet);
            expBad    = memDet ? badAddrMem : badAddrIf;
            #1;
            checkBit("mem flush", memDet, memExceptionFlush);
            checkBit("ex flush", memDet | exDet, exExceptionFlush);
            checkBit("id flush", memDet | exDet | idDet, idExceptionFlush);
            checkBit("if flush", memDet | exDet | idDet | ifDet, ifExceptionFlush);
            checkBit("exception select", 1'b1, excPcSel);
            checkWord("exception vector", expectedVector(1'b0, 1'b0, '0, 1'b0, 1'b1), excPcOut);
            @(negedge clock);
            clearExceptions();
            readReg(cp0Pkg::regCause, value);
            checkCode("priority code", expCode, value[cp0Pkg::causeCodeLsb +: 4]);
            readReg(cp0Pkg::regEpc, readValue);
            checkWord("priority epc", expEpc, readValue);
            readReg(cp0Pkg::regBadVAddr, readValue);
            if (badLoaded)
                checkWord("bad address", expBad, readValue);
        end

        // Masked ID exception leaves Cause alone
        writeReg(cp0Pkg::regStatus, bootStatus);
        excOv    = 1'b1;                 // Known code to compare against
        exCanErr = 1'b1;
        idCanErr = 1'b1;
        @(negedge clock);
        clearExceptions();
        writeReg(cp0Pkg::regStatus, bootStatus);
        memCanErr = 1'b1;
        excSys    = 1'b1;
        #1;
        checkBit("masked id stall", 1'b1, idExceptionStall);
        checkBit("masked select", 1'b0, excPcSel);
        @(negedge clock);
        clearExceptions();
        ifStall = 1'b1;                  // Fetch stall holds MEM back
        excAdEL = 1'b1;
        #1;
        checkBit("mem stall", 1'b1, memExceptionStall);
        @(negedge clock);
        ifStall = 1'b0;
        clearExceptions();
        memCanErr = 1'b1;
        excOv     = 1'b1;
        #1;
        checkBit("ex stall", 1'b1, exExceptionStall);
        @(negedge clock);
        clearExceptions();
        idCanErr = 1'b1;                 // Older stage may still fault
        excAdIf  = 1'b1;
        #1;
        checkBit("if stall", 1'b1, ifExceptionStall);
        @(negedge clock);
        clearExceptions();
        readReg(cp0Pkg::regCause, value);
        checkCode("masked code", cp0Pkg::excOv, value[cp0Pkg::causeCodeLsb +: 4]);
        readReg(cp0Pkg::regStatus, value);
        checkBit("masked exl", 1'b0, value[cp0Pkg::statusExlBit]);
        readReg(cp0Pkg::regEpc, oldValue);
        idStall = 1'b1;
        writeReg(cp0Pkg::regEpc, ~oldValue);
        idStall = 1'b0;
        readReg(cp0Pkg::regEpc, readValue);
        checkWord("stalled write", oldValue, readValue);

        // Interrupt on line 2 through the special vector
        value = nextRandom();
        bev   = value[0];
        writeReg(cp0Pkg::regCause, 32'h0080_0000);                      // IV only
        writeReg(cp0Pkg::regStatus, 32'h0000_0401 | {9'd0, bev, 22'd0}); // IM2 and IE
        idRestartPc = nextRandom() & ~32'h0000_0003;
        extInt = 5'b00001;
        cycle  = 0;
        seen   = 1'b0;
        while (!seen && cycle < 10) begin
            #1;
            if (excPcSel)
                seen = 1'b1;
            else begin
                @(negedge clock);
                cycle++;
            end
        end
        if (!seen) begin
            errorCount++;
            $display("ERROR: external interrupt was never taken");
        end
        checkWord("interrupt vector", expectedVector(1'b0, 1'b0, '0, 1'b1, bev), excPcOut);
        @(negedge clock);
        extInt = '0;
        readReg(cp0Pkg::regStatus, value);
        checkBit("interrupt exl", 1'b1, value[cp0Pkg::statusExlBit]);
        readReg(cp0Pkg::regEpc, readValue);
        checkWord("interrupt epc", idRestartPc, readValue);
        eret = 1'b1;
        #1;
        checkBit("eret select", 1'b1, excPcSel);
        checkWord("eret vector", expectedVector(1'b0, 1'b1, idRestartPc, 1'b0, bev), excPcOut);
        @(negedge clock);
        eret = 1'b0;
        readReg(cp0Pkg::regStatus, value);
        checkBit("eret exl", 1'b0, value[cp0Pkg::statusExlBit]);

        // User mode makes CP0 access trap
        writeReg(cp0Pkg::regStatus, userStatus);
        #1;
        checkBit("user mode", 1'b0, kernelMode);
        @(negedge clock);
        readReg(cp0Pkg::regStatus, value);                  // Also traps and sets EXL again
        checkWord("user read", 32'd0, value);
        excOv = 1'b1;                                       // Move Cause off CpU
        @(negedge clock);
        excOv = 1'b0;
        writeReg(cp0Pkg::regStatus, userStatus);
        mtc0  = 1'b1;
        rd    = cp0Pkg::regEpc;
        regIn = nextRandom();
        #1;
        checkBit("cpu select", 1'b1, excPcSel);
        checkWord("cpu vector", expectedVector(1'b0, 1'b0, '0, 1'b0, 1'b1), excPcOut);
        @(negedge clock);
        mtc0 = 1'b0;
        readReg(cp0Pkg::regCause, value);
        checkCode("cpu code", cp0Pkg::excCpU, value[cp0Pkg::causeCodeLsb +: 4]);

        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

/* all.f */
design/cp0Pkg.sv
design/cp0Timer.sv
design/cp0Registers.sv
design/exceptionArbiter.sv
design/cp0Top.sv
dv/cp0Tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module cp0Tb

output=$(./obj_dir/Vcp0Tb)
echo "$output"

if echo "$output" | grep -qx "SIMULATION PASSED"; then
    exit 0
fi
exit 1
